// File: hdl/mem_ctl_pkg.sv
// widths, stream structs and enums shared by the memory controller stages
package mem_ctl_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int ADDR_WIDTH = 16;             // word address
    localparam int DATA_WIDTH = 32;             // one data word
    localparam int BE_WIDTH   = DATA_WIDTH / 8; // one enable per byte
    localparam int SIZE_WIDTH = 3;              // burstcount, 1 to 7 beats

    ////////////////////
    // enums
    ////////////////////
    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cmd_op_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,    // waiting for a command
        ST_WRITE = 2'd1,    // draining write beats
        ST_READ  = 2'd2     // returning read beats
    } engine_state_t;

    ////////////////////
    // stream payloads
    ////////////////////
    typedef struct packed {
        cmd_op_t               op;
        logic [ADDR_WIDTH-1:0] addr;   // first word of the burst
        logic [SIZE_WIDTH-1:0] len;    // beats in the burst
    } mem_cmd_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [BE_WIDTH-1:0]   be;
        logic                  last;   // final beat of the burst
    } wr_beat_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  error;  // address outside the array
        logic                  first;  // first beat of the burst
        logic                  last;   // final beat of the burst
    } rd_beat_t;

endpackage

// File: hdl/mm_st_converter.sv
`timescale 1ns/1ps
// avalon-mm slave to command and write-data streams, read beats back to host
module mm_st_converter
(
    input  logic                               ctl_clk,
    input  logic                               ctl_reset_n,
    // avalon-mm slave
    output logic                               avl_ready,       // waitrequest_n
    input  logic                               avl_read_req,
    input  logic                               avl_write_req,
    input  logic [mem_ctl_pkg::SIZE_WIDTH-1:0] avl_size,        // burstcount
    input  logic [mem_ctl_pkg::ADDR_WIDTH-1:0] avl_addr,
    input  logic [mem_ctl_pkg::DATA_WIDTH-1:0] avl_wdata,
    input  logic [mem_ctl_pkg::BE_WIDTH-1:0]   avl_be,
    output logic                               avl_rdata_valid,
    output logic [mem_ctl_pkg::DATA_WIDTH-1:0] avl_rdata,
    output logic                               avl_rdata_error,
    // command stream
    output logic                               cmd_valid,
    input  logic                               cmd_ready,
    output mem_ctl_pkg::mem_cmd_t              cmd,
    // write-data stream
    output logic                               wr_valid,
    input  logic                               wr_ready,
    output mem_ctl_pkg::wr_beat_t              wr,
    // read-data stream, no back-pressure
    input  logic                               rd_valid,
    input  mem_ctl_pkg::rd_beat_t              rd
);
    import mem_ctl_pkg::*;

    logic                  data_pass;      // rest of a write burst, data beats only
    logic [SIZE_WIDTH-1:0] burst_counter;  // beats left in the burst
    logic                  wr_take;        // write beat accepted this cycle
    logic                  first_wr;       // first beat of a write request

    // a request needs both streams, a data beat only the write stream
    assign avl_ready = data_pass ? wr_ready : (wr_ready & cmd_ready);

    // command only on the first beat, and only when the host sees ready
    assign cmd_valid = ~data_pass & wr_ready & (avl_read_req | avl_write_req);
    assign cmd.op    = avl_write_req ? OP_WRITE : OP_READ;
    assign cmd.addr  = avl_addr;
    assign cmd.len   = avl_size;

    assign wr_valid  = avl_write_req & (data_pass | cmd_ready);
    assign wr.data   = avl_wdata;
    assign wr.be     = avl_be;
    // single beats and the counted final beat close the burst
    assign wr.last   = data_pass ? (burst_counter == SIZE_WIDTH'(1))
                                 : (avl_size <= SIZE_WIDTH'(1));

    assign wr_take   = wr_valid & wr_ready;
    assign first_wr  = wr_take & ~data_pass;

    ////////////////////
    // read path
    ////////////////////
    assign avl_rdata_valid = rd_valid;     // host always accepts
    assign avl_rdata       = rd.data;
    assign avl_rdata_error = rd.error;

    ////////////////////
    // burst tracking
    ////////////////////
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            data_pass     <= 1'b0;
            burst_counter <= '0;
        end
        else if (first_wr && avl_size > SIZE_WIDTH'(1))
        begin
            data_pass     <= 1'b1;
            burst_counter <= avl_size - SIZE_WIDTH'(1);   // beats after this one
        end
        else if (wr_take && data_pass)
        begin
            burst_counter <= burst_counter - SIZE_WIDTH'(1);
            if (burst_counter == SIZE_WIDTH'(1))
                data_pass <= 1'b0;                       // last data beat taken
        end
    end

endmodule

// File: hdl/request_queue.sv
`timescale 1ns/1ps
// command FIFO and write-data FIFO between converter and burst engine
module request_queue #(
    parameter int QUEUE_DEPTH = 4    // entries per FIFO, power of two
)(
    input  logic                  ctl_clk,
    input  logic                  ctl_reset_n,
    input  logic                  cmd_valid,
    input  mem_ctl_pkg::mem_cmd_t cmd,
    output logic                  cmd_ready,
    input  logic                  wr_valid,
    input  mem_ctl_pkg::wr_beat_t wr,
    output logic                  wr_ready,
    output logic                  q_cmd_valid,
    output mem_ctl_pkg::mem_cmd_t q_cmd,
    input  logic                  q_cmd_ready,
    output logic                  q_wr_valid,
    output mem_ctl_pkg::wr_beat_t q_wr,
    input  logic                  q_wr_ready
);
    import mem_ctl_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    mem_cmd_t     cmd_mem [QUEUE_DEPTH];   // command storage
    wr_beat_t     wr_mem  [QUEUE_DEPTH];   // write beat storage
    logic [PTR_W:0] cmd_wptr;              // msb is the wrap bit
    logic [PTR_W:0] cmd_rptr;
    logic [PTR_W:0] wr_wptr;
    logic [PTR_W:0] wr_rptr;

    // full when indices match and wrap bits differ
    assign cmd_ready   = (cmd_wptr ^ cmd_rptr) != {1'b1, {PTR_W{1'b0}}};
    assign wr_ready    = (wr_wptr ^ wr_rptr) != {1'b1, {PTR_W{1'b0}}};
    assign q_cmd_valid = cmd_wptr != cmd_rptr;     // not empty
    assign q_wr_valid  = wr_wptr != wr_rptr;
    assign q_cmd       = cmd_mem[cmd_rptr[PTR_W-1:0]];
    assign q_wr        = wr_mem[wr_rptr[PTR_W-1:0]];

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            cmd_wptr <= '0;
            cmd_rptr <= '0;
            wr_wptr  <= '0;
            wr_rptr  <= '0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                cmd_wptr <= cmd_wptr + 1'b1;
            if (q_cmd_valid && q_cmd_ready)
                cmd_rptr <= cmd_rptr + 1'b1;
            if (wr_valid && wr_ready)
                wr_wptr  <= wr_wptr + 1'b1;
            if (q_wr_valid && q_wr_ready)
                wr_rptr  <= wr_rptr + 1'b1;
        end
    end

    // payload storage
    always_ff @(posedge ctl_clk)
    begin
        if (cmd_valid && cmd_ready)
            cmd_mem[cmd_wptr[PTR_W-1:0]] <= cmd;
        if (wr_valid && wr_ready)
            wr_mem[wr_wptr[PTR_W-1:0]] <= wr;
    end

endmodule

// File: hdl/burst_engine.sv
`timescale 1ns/1ps
// burst engine FSM with the word array, executes queued commands in order
module burst_engine #(
    parameter int MEM_WORDS = 256    // words implemented in the array
)(
    input  logic                  ctl_clk,
    input  logic                  ctl_reset_n,
    input  logic                  q_cmd_valid,
    input  mem_ctl_pkg::mem_cmd_t q_cmd,
    output logic                  q_cmd_ready,
    input  logic                  q_wr_valid,
    input  mem_ctl_pkg::wr_beat_t q_wr,
    output logic                  q_wr_ready,
    output logic                  rd_valid,
    output mem_ctl_pkg::rd_beat_t rd
);
    import mem_ctl_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    engine_state_t         state;
    logic [ADDR_WIDTH-1:0] beat_addr;      // address of the current beat
    logic [SIZE_WIDTH-1:0] burst_len;      // beats in the running read
    logic [SIZE_WIDTH-1:0] beat_idx;       // read beat number
    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
    logic [IDX_W-1:0]      mem_idx;
    logic                  in_range;       // beat_addr inside the array
    logic                  wr_fire;        // write beat popped
    logic                  rd_last;        // final read beat this cycle

    assign q_cmd_ready = (state == ST_IDLE);   // one command at a time
    assign q_wr_ready  = (state == ST_WRITE);
    assign wr_fire     = q_wr_valid & q_wr_ready;

    assign mem_idx  = beat_addr[IDX_W-1:0];
    assign in_range = 32'(beat_addr) < MEM_WORDS;
    // a zero burstcount runs as one beat
    assign rd_last  = (beat_idx == burst_len - SIZE_WIDTH'(1)) || (burst_len == '0);

    ////////////////////
    // control FSM
    ////////////////////
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            state     <= ST_IDLE;
            beat_addr <= '0;
            burst_len <= '0;
            beat_idx  <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (q_cmd_valid)
                    begin
                        beat_addr <= q_cmd.addr;
                        burst_len <= q_cmd.len;
                        beat_idx  <= '0;
                        state     <= (q_cmd.op == OP_WRITE) ? ST_WRITE : ST_READ;
                    end
                ST_WRITE:
                    if (q_wr_valid)                      // stalls on an empty FIFO
                    begin
                        beat_addr <= beat_addr + 1'b1;   // no wrap across the burst
                        if (q_wr.last)
                            state <= ST_IDLE;
                    end
                ST_READ:
                begin
                    beat_addr <= beat_addr + 1'b1;
                    beat_idx  <= beat_idx + 1'b1;
                    if (rd_last)
                        state <= ST_IDLE;
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////
    // word array
    ////////////////////
    // byte merge, out of range beats dropped
    always_ff @(posedge ctl_clk)
    begin
        if (wr_fire && in_range)
        begin
            for (int b = 0; b < BE_WIDTH; b++)
            begin
                if (q_wr.be[b])
                    mem[mem_idx][8*b +: 8] <= q_wr.data[8*b +: 8];
            end
        end
    end

    // read beats straight from the array
    assign rd_valid = (state == ST_READ);
    assign rd.data  = in_range ? mem[mem_idx] : '0;
    assign rd.error = ~in_range;
    assign rd.first = (beat_idx == '0);
    assign rd.last  = rd_last;

endmodule

// File: hdl/mem_ctl_top.sv
`timescale 1ns/1ps
// memory controller front end, converter then queue then burst engine
module mem_ctl_top #(
    parameter int QUEUE_DEPTH = 4,     // entries per FIFO
    parameter int MEM_WORDS   = 256    // words in the array
)(
    input  logic                               ctl_clk,
    input  logic                               ctl_reset_n,
    output logic                               avl_ready,
    input  logic                               avl_read_req,
    input  logic                               avl_write_req,
    input  logic [mem_ctl_pkg::SIZE_WIDTH-1:0] avl_size,
    input  logic [mem_ctl_pkg::ADDR_WIDTH-1:0] avl_addr,
    input  logic [mem_ctl_pkg::DATA_WIDTH-1:0] avl_wdata,
    input  logic [mem_ctl_pkg::BE_WIDTH-1:0]   avl_be,
    output logic                               avl_rdata_valid,
    output logic [mem_ctl_pkg::DATA_WIDTH-1:0] avl_rdata,
    output logic                               avl_rdata_error
);
    import mem_ctl_pkg::*;

    // converter to queue
    logic     cmd_valid;
    logic     cmd_ready;
    mem_cmd_t cmd;
    logic     wr_valid;
    logic     wr_ready;
    wr_beat_t wr;
    // queue to engine
    logic     q_cmd_valid;
    logic     q_cmd_ready;
    mem_cmd_t q_cmd;
    logic     q_wr_valid;
    logic     q_wr_ready;
    wr_beat_t q_wr;
    // engine back to converter
    logic     rd_valid;
    rd_beat_t rd;

    mm_st_converter u_conv (.*);

    request_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (.*);

    burst_engine #(.MEM_WORDS(MEM_WORDS)) u_engine (.*);

endmodule

// File: tests/mem_ctl_chk.sv
`timescale 1ns/1ps
// concurrent checks on the mem_ctl_top host ports
module mem_ctl_chk
(
    input logic ctl_clk,
    input logic ctl_reset_n,
    input logic avl_ready,
    input logic avl_rdata_valid
);

    ////////////////////
    // reset behavior
    ////////////////////
    // no read beats while held in reset
    rdata_idle_in_reset: assert property (
        @(posedge ctl_clk) !ctl_reset_n |-> !avl_rdata_valid
    ) else $error("avl_rdata_valid high during reset");

    ////////////////////
    // known strobes
    ////////////////////
    rdata_valid_known: assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n) !$isunknown(avl_rdata_valid)
    ) else $error("avl_rdata_valid unknown after reset");

    ready_known: assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n) !$isunknown(avl_ready)
    ) else $error("avl_ready unknown after reset");    // host handshake

endmodule

// File: tests/mem_ctl_tb.sv
`timescale 1ns/1ps
// testbench for mem_ctl_top, runs the request cases from the data file
// against a model array and checks every returned read beat
module mem_ctl_tb;
    import mem_ctl_pkg::*;

    localparam int QUEUE_DEPTH   = 4;
    localparam int MEM_WORDS     = 256;
    localparam int REQ_TIMEOUT   = 200;    // cycles a request may wait for avl_ready
    localparam int DRAIN_TIMEOUT = 500;    // cycles to collect the last read beats
    localparam logic [DATA_WIDTH-1:0] BEAT_STEP = 32'h0101_0101;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  error;      // beat outside the array
    } exp_beat_t;

    logic                  ctl_clk;
    logic                  ctl_reset_n;
    logic                  avl_ready;
    logic                  avl_read_req;
    logic                  avl_write_req;
    logic [SIZE_WIDTH-1:0] avl_size;
    logic [ADDR_WIDTH-1:0] avl_addr;
    logic [DATA_WIDTH-1:0] avl_wdata;
    logic [BE_WIDTH-1:0]   avl_be;
    logic                  avl_rdata_valid;
    logic [DATA_WIDTH-1:0] avl_rdata;
    logic                  avl_rdata_error;

    logic [DATA_WIDTH-1:0] model_mem [MEM_WORDS];  // expected array contents
    exp_beat_t             exp_q [$];              // read beats still due, in order
    int                    mismatch_count;
    int                    error_count;
    int                    check_count;
    int                    stall_cycles;           // write cycles with avl_ready low
    bit                    timed_out;

    mem_ctl_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .MEM_WORDS  (MEM_WORDS)
    ) DUT (.*);

    bind mem_ctl_top mem_ctl_chk u_chk (
        .ctl_clk        (ctl_clk),
        .ctl_reset_n    (ctl_reset_n),
        .avl_ready      (avl_ready),
        .avl_rdata_valid(avl_rdata_valid)
    );

    initial ctl_clk = 1'b0;
    always #50 ctl_clk = ~ctl_clk;         // 100 ns period

    ////////////////////
    // model and drivers
    ////////////////////
    // enabled bytes from the new word, the rest kept
    function automatic logic [DATA_WIDTH-1:0] merge_bytes(
        input logic [DATA_WIDTH-1:0] old_word,
        input logic [DATA_WIDTH-1:0] new_word,
        input logic [BE_WIDTH-1:0]   be
    );
        logic [DATA_WIDTH-1:0] result;
        result = old_word;
        for (int b = 0; b < BE_WIDTH; b++)
        begin
            if (be[b])
                result[8*b +: 8] = new_word[8*b +: 8];
        end
        return result;
    endfunction

    // request held until a rising edge sees avl_ready
    task automatic wait_accept();
        int waited;
        bit taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < REQ_TIMEOUT)
        begin
            @(posedge ctl_clk);
            taken = avl_ready;
            if (!taken)
            begin
                if (avl_write_req)
                    stall_cycles++;        // write back-pressure only
                waited++;
            end
        end
        if (!taken)
        begin
            timed_out = 1'b1;
            $display("ERROR: request at address %h not accepted within %0d cycles",
                     avl_addr, REQ_TIMEOUT);
        end
    endtask

    // one case, starting and ending on a falling edge
    task automatic run_case(
        input bit                    is_write,
        input logic [ADDR_WIDTH-1:0] addr,
        input int                    len,
        input logic [DATA_WIDTH-1:0] seed,
        input logic [BE_WIDTH-1:0]   be
    );
        int                    word;
        logic [DATA_WIDTH-1:0] wdata;
        exp_beat_t             beat;
        if (!is_write)
        begin
            for (int i = 0; i < len; i++)
            begin
                word       = int'(addr) + i;
                beat.error = (word >= MEM_WORDS);       // past the array reads zero
                beat.data  = beat.error ? '0 : model_mem[word];
                exp_q.push_back(beat);
            end
        end
        // a read is one cycle, a write one cycle per beat
        for (int i = 0; i < (is_write ? len : 1) && !timed_out; i++)
        begin
            wdata         = seed + BEAT_STEP * 32'(i);
            avl_read_req  = !is_write;
            avl_write_req = is_write;
            avl_size      = SIZE_WIDTH'(len);
            avl_addr      = addr;
            avl_wdata     = is_write ? wdata : '0;
            avl_be        = be;
            word          = int'(addr) + i;
            if (is_write && word < MEM_WORDS)           // dropped past the array
                model_mem[word] = merge_bytes(model_mem[word], wdata, be);
            wait_accept();
            @(negedge ctl_clk);
        end
        avl_read_req  = 1'b0;
        avl_write_req = 1'b0;
    endtask

    ////////////////////
    // read monitor
    ////////////////////
    always @(posedge ctl_clk)
    begin
        exp_beat_t exp_beat;
        if (ctl_reset_n && avl_rdata_valid)
        begin
            if (exp_q.size() == 0)
            begin
                error_count++;
                $display("ERROR: read data returned with no read outstanding");
            end
            else
            begin
                exp_beat = exp_q.pop_front();
                check_count += 2;
                assert (avl_rdata === exp_beat.data)
                else
                begin
                    mismatch_count++;
                    $display("MISMATCH avl_rdata: got %h, expected %h",
                             avl_rdata, exp_beat.data);
                end
                assert (avl_rdata_error === exp_beat.error)
                else
                begin
                    mismatch_count++;
                    $display("MISMATCH avl_rdata_error: got %h, expected %h",
                             avl_rdata_error, exp_beat.error);
                end
            end
        end
    end

    ////////////////////
    // main sequence
    ////////////////////
    initial
    begin
        int                    fd;
        int                    n;
        int                    idle;
        int                    waited;
        string                 line;
        logic [3:0]            op;           // bit 0 write, bit 1 no idle after
        logic [ADDR_WIDTH-1:0] addr;
        int                    len;
        logic [DATA_WIDTH-1:0] seed;
        logic [BE_WIDTH-1:0]   be;

        void'($urandom(32'hd677_944e));      // one seed for the run
        mismatch_count = 0;
        error_count    = 0;
        check_count    = 0;
        stall_cycles   = 0;
        timed_out      = 1'b0;
        ctl_reset_n    = 1'b0;
        avl_read_req   = 1'b0;
        avl_write_req  = 1'b0;
        avl_size       = '0;
        avl_addr       = '0;
        avl_wdata      = '0;
        avl_be         = '0;
        foreach (model_mem[i])
            model_mem[i] = '0;

        repeat (16) @(negedge ctl_clk);
        ctl_reset_n = 1'b1;
        @(negedge ctl_clk);
        check_count += 2;
        assert (avl_rdata_valid === 1'b0)
        else
        begin
            mismatch_count++;
            $display("MISMATCH avl_rdata_valid: got %h, expected 0", avl_rdata_valid);
        end
        assert (avl_ready === 1'b1)
        else
        begin
            mismatch_count++;
            $display("MISMATCH avl_ready: got %h, expected 1", avl_ready);
        end

        fd = $fopen("tests/mem_ctl_cases.txt", "r");
        if (fd == 0)
        begin
            error_count++;
            $display("ERROR: cannot open the cases file");
        end
        else
        begin
            while (!$feof(fd) && !timed_out)
            begin
                line = "";
                n    = $fgets(line, fd);
                n    = $sscanf(line, "%h %h %d %h %h", op, addr, len, seed, be);
                if (n == 5)                          // comments and blanks skipped
                begin
                    run_case(op[0], addr, len, seed, be);
                    idle = op[1] ? 0 : int'($urandom % 4);
                    repeat (idle) @(negedge ctl_clk);
                end
            end
            $fclose(fd);
        end

        // outstanding reads
        waited = 0;
        while (exp_q.size() != 0 && !timed_out && waited < DRAIN_TIMEOUT)
        begin
            @(negedge ctl_clk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            timed_out = 1'b1;
            $display("ERROR: %0d read beats never returned", exp_q.size());
        end
        repeat (4) @(negedge ctl_clk);            // stray beats show up here

        check_count++;
        assert (stall_cycles > 0)
        else
        begin
            error_count++;
            $display("ERROR: avl_ready never dropped during the long write run");
        end

        $display("checks %0d, mismatches %0d, other errors %0d, timeout %0d",
                 check_count, mismatch_count, error_count, timed_out);
        if (mismatch_count == 0 && error_count == 0 && !timed_out)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: tests/mem_ctl_cases.txt
# op addr len seed be, op 0 read, 1 write, 2 read and 3 write with no idle cycles after
# addr, seed and be in hex, len in decimal beats, beat i data is seed + i * 01010101
1 0000 1 a5a50001 f
1 0001 1 5a5a0002 f
0 0000 1 0 f
0 0001 1 0 f
1 0010 4 10203040 f
1 0020 7 c0de0000 f
1 0030 2 0badf00d f
2 0030 2 0 f
2 0020 7 0 f
0 0010 4 0 f
1 0011 1 deadbeef 5
1 0022 3 ffffffff 8
2 0010 4 0 f
0 0020 7 0 f
3 0040 7 11110000 f
3 0047 7 22220000 f
3 004e 7 33330000 f
1 0055 7 44440000 f
2 0040 7 0 f
2 0047 7 0 f
2 004e 7 0 f
0 0055 7 0 f
1 00fd 6 66660000 f
1 0100 1 77777777 f
1 1234 2 88880000 f
0 00fd 6 0 f
0 0000 2 0 f

// File: filelist.f
hdl/mem_ctl_pkg.sv
hdl/mm_st_converter.sv
hdl/request_queue.sv
hdl/burst_engine.sv
hdl/mem_ctl_top.sv
tests/mem_ctl_chk.sv
tests/mem_ctl_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = mem_ctl_tb
FILELIST  = filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
